// ==== beat_counter.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module beat_counter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_rd_en,
    output cpri_frame_pkg::rd_step_t o_step
);

    logic [2:0]            beat_q;
    logic [3:0]            group_q;
    logic [`CP_ADDR_W-1:0] addr_q;
    logic                  group_end;

    assign group_end = (beat_q == 3'(`CP_GROUP_BEATS - 1));

    always_ff @(posedge clk)
    begin
        if (rst || !i_rd_en)
        begin
            beat_q  <= '0;
            group_q <= '0;
            addr_q  <= `CP_ADDR_W'(`CP_DATA_BASE);
        end
        else
        begin
            beat_q <= group_end ? '0 : beat_q + 3'd1;
            if (group_end)
            begin
                group_q <= (group_q == 4'(`CP_GROUP_NUM - 1)) ? '0 : group_q + 4'd1;
            end
            // slot beat carries no data address
            if (beat_q != 3'd0)
            begin
                addr_q <= (addr_q == `CP_ADDR_W'(`CP_DATA_LAST)) ?
                          `CP_ADDR_W'(`CP_DATA_BASE) : addr_q + 1'b1;
            end
        end
    end

    assign o_step = '{beat_idx:  beat_q,
                      group_idx: group_q,
                      data_addr: addr_q,
                      last:      group_end && (group_q == 4'(`CP_GROUP_NUM - 1))};

endmodule

// ==== build.f ====
+incdir+.
cpri_pkt_pkg.sv
cpri_frame_pkg.sv
pkt_capture.sv
pingpong_buffer.sv
readout_fsm.sv
beat_counter.sv
lane_packer.sv
slot_mapper.sv
cpri_pack_top.sv
tb_cpri_pack.sv

// ==== cpri_frame_pkg.sv ====
`include "cpri_pack_cfg.svh"

package cpri_frame_pkg;

    // packed data word, lane n belongs to antenna n
    typedef struct packed {
        logic [`CP_ANT_NUM-1:0][15:0] lane;
    } lanes16_t;

    // an output word is either sample lanes or a header
    typedef union packed {
        lanes16_t                lanes;
        cpri_pkt_pkg::pkt_head_t head;
    } cpri_word_u;

    typedef struct packed {
        logic                  wen;
        logic [`CP_ADDR_W-1:0] waddr;
        cpri_word_u            wdata;
        logic                  wlast;
    } cpri_wr_t;

    // readout position, one per read cycle
    typedef struct packed {
        logic [2:0]            beat_idx;
        logic [3:0]            group_idx;
        logic [`CP_ADDR_W-1:0] data_addr;
        logic                  last;
    } rd_step_t;

endpackage

// ==== cpri_pack_cfg.svh ====
`ifndef CPRI_PACK_CFG_SVH
`define CPRI_PACK_CFG_SVH

// ------------------------------------------------
// antenna lanes and sample format
// ------------------------------------------------
`define CP_ANT_NUM          4
`define CP_SAMPLE_W         14
`define CP_SHIFT_W          4

// packet and readout group geometry
`define CP_PKT_BEATS        96
`define CP_GROUP_BEATS      8
`define CP_GROUP_NUM        12

// ------------------------------------------------
// cpri buffer side
// ------------------------------------------------
`define CP_WORD_W           64
`define CP_ADDR_W           7
`define CP_DATA_BASE        7
`define CP_DATA_LAST        90
`define CP_HIGH_SLOT_BASE   91

`endif

// ==== cpri_pack_top.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module cpri_pack_top (
    input  logic                     clk,
    input  logic                     rst,
    input  cpri_pkt_pkg::beat_t      i_beat,
    output cpri_frame_pkg::cpri_wr_t o_wr
);

    cpri_pkt_pkg::pkt_head_t                  cap_head;
    cpri_pkt_pkg::shift_words_t               cap_shift;
    cpri_pkt_pkg::pkt_head_t                  rd_head;
    cpri_pkt_pkg::shift_words_t               rd_shift;
    cpri_frame_pkg::rd_step_t                 rd_step;
    cpri_frame_pkg::rd_step_t                 pk_step;
    cpri_frame_pkg::lanes16_t                 pk_lanes;
    logic [`CP_ANT_NUM-1:0][`CP_SAMPLE_W-1:0] rd_samples;
    logic                                     rd_en;
    logic                                     rd_release;
    logic                                     full_next;

    // ------------------------------------------------
    // write path
    // ------------------------------------------------
    pkt_capture pkt_capture_i (
        .clk     (clk),
        .rst     (rst),
        .i_beat  (i_beat),
        .o_head  (cap_head),
        .o_shift (cap_shift)
    );

    pingpong_buffer pingpong_buffer_i (
        .clk         (clk),
        .rst         (rst),
        .i_beat      (i_beat),
        .i_head      (cap_head),
        .i_shift     (cap_shift),
        .i_rd_en     (rd_en),
        .i_beat_idx  (rd_step.beat_idx),
        .i_group_idx (rd_step.group_idx),
        .i_release   (rd_release),
        .o_full_next (full_next),
        .o_samples   (rd_samples),
        .o_head      (rd_head),
        .o_shift     (rd_shift)
    );

    // ------------------------------------------------
    // read path
    // ------------------------------------------------
    readout_fsm readout_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .i_full_next (full_next),
        .i_last      (rd_step.last),
        .o_rd_en     (rd_en),
        .o_release   (rd_release)
    );

    beat_counter beat_counter_i (
        .clk     (clk),
        .rst     (rst),
        .i_rd_en (rd_en),
        .o_step  (rd_step)
    );

    lane_packer lane_packer_i (
        .clk       (clk),
        .rst       (rst),
        .i_samples (rd_samples),
        .i_step    (rd_step),
        .o_lanes   (pk_lanes),
        .o_step    (pk_step)
    );

    slot_mapper slot_mapper_i (
        .clk      (clk),
        .rst      (rst),
        .i_lanes  (pk_lanes),
        .i_step   (pk_step),
        .i_rd_vld (rd_en),
        .i_head   (rd_head),
        .i_shift  (rd_shift),
        .o_wr     (o_wr)
    );

endmodule

// ==== cpri_pkt_pkg.sv ====
`include "cpri_pack_cfg.svh"

package cpri_pkt_pkg;

    // one antenna per beat
    typedef struct packed {
        logic [`CP_SHIFT_W-1:0]  shift;
        logic [`CP_SAMPLE_W-1:0] sample;
    } lane_in_t;

    // header word as written to the slot area
    typedef struct packed {
        logic [3:0]               ch_type;
        logic                     cell_idx;
        logic [6:0]               slot_idx;
        logic [3:0]               sym_idx;
        logic [8:0]               prb_idx;
        logic [3:0]               info_hi;
        logic [`CP_WORD_W-30:0]   pad;
    } pkt_head_t;

    // input beat, header fields are those of antenna 0
    typedef struct packed {
        logic                          vld;
        logic                          sop;
        logic                          eop;
        logic [3:0]                    ch_type;
        logic                          cell_idx;
        logic [6:0]                    slot_idx;
        logic [3:0]                    sym_idx;
        logic [8:0]                    prb_idx;
        logic [3:0]                    info_hi;
        lane_in_t [`CP_ANT_NUM-1:0]    lane;
    } beat_t;

    // word0 holds antennas 1:0, word1 holds antennas 3:2
    typedef struct packed {
        logic [`CP_WORD_W-1:0] word1;
        logic [`CP_WORD_W-1:0] word0;
    } shift_words_t;

endpackage

// ==== lane_packer.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module lane_packer (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [`CP_ANT_NUM-1:0][`CP_SAMPLE_W-1:0] i_samples,
    input  cpri_frame_pkg::rd_step_t                 i_step,
    output cpri_frame_pkg::lanes16_t                 o_lanes,
    output cpri_frame_pkg::rd_step_t                 o_step
);

    logic [`CP_ANT_NUM-1:0][`CP_SAMPLE_W-1:0] prev_q;
    cpri_frame_pkg::rd_step_t                 step_d1;
    cpri_frame_pkg::lanes16_t                 lanes_d;

    // step lines up with the buffer read data
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            step_d1 <= '0;
            o_step  <= '0;
        end
        else
        begin
            step_d1 <= i_step;
            o_step  <= step_d1;
        end
    end

    // ------------------------------------------------
    // 8 x 14 bit joined lowest first, cut into 7 x 16
    // ------------------------------------------------
    always_comb
    begin
        lanes_d = '0;
        if (step_d1.beat_idx != 3'd0)
        begin
            for (int a = 0; a < `CP_ANT_NUM; a++)
            begin
                // slice k starts 2*(k-1) bits into the previous sample
                lanes_d.lane[a] = 16'({i_samples[a], prev_q[a]} >>
                                      {step_d1.beat_idx - 3'd1, 1'b0});
            end
        end
    end

    always_ff @(posedge clk)
    begin
        prev_q  <= i_samples;
        o_lanes <= lanes_d;
    end

endmodule

// ==== pingpong_buffer.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module pingpong_buffer (
    input  logic                                      clk,
    input  logic                                      rst,
    input  cpri_pkt_pkg::beat_t                       i_beat,
    input  cpri_pkt_pkg::pkt_head_t                   i_head,
    input  cpri_pkt_pkg::shift_words_t                i_shift,
    input  logic                                      i_rd_en,
    input  logic [2:0]                                i_beat_idx,
    input  logic [3:0]                                i_group_idx,
    input  logic                                      i_release,
    output logic                                      o_full_next,
    output logic [`CP_ANT_NUM-1:0][`CP_SAMPLE_W-1:0]  o_samples,
    output cpri_pkt_pkg::pkt_head_t                   o_head,
    output cpri_pkt_pkg::shift_words_t                o_shift
);

    logic [`CP_ANT_NUM-1:0][`CP_SAMPLE_W-1:0] mem [2][`CP_PKT_BEATS];
    logic [`CP_ANT_NUM-1:0][`CP_SAMPLE_W-1:0] wr_samples;
    cpri_pkt_pkg::pkt_head_t                  head_mem [2];
    cpri_pkt_pkg::shift_words_t               shift_mem [2];
    logic [`CP_ADDR_W-1:0] wr_addr;
    logic [`CP_ADDR_W-1:0] rd_addr;
    logic [1:0]            full_q;
    logic                  wr_bank;
    logic                  rd_bank;
    logic                  pkt_end;

    assign pkt_end = i_beat.vld && i_beat.eop;

    always_comb
    begin
        for (int a = 0; a < `CP_ANT_NUM; a++)
        begin
            wr_samples[a] = i_beat.lane[a].sample;
        end
    end

    // ------------------------------------------------
    // write side
    // ------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (i_beat.vld)
        begin
            mem[wr_bank][wr_addr] <= wr_samples;
        end
        if (pkt_end)
        begin
            head_mem[wr_bank]  <= i_head;
            shift_mem[wr_bank] <= i_shift;
        end
    end

    // bank pointers and full flags
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            full_q  <= '0;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            wr_addr <= '0;
        end
        else
        begin
            if (i_release)
            begin
                full_q[rd_bank] <= 1'b0;
                rd_bank         <= ~rd_bank;
            end
            if (pkt_end)
            begin
                full_q[wr_bank] <= 1'b1;
                wr_bank         <= ~wr_bank;
            end
            if (i_beat.vld)
            begin
                wr_addr <= i_beat.eop ? '0 : wr_addr + 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // read side, group*8 + beat
    // ------------------------------------------------
    assign rd_addr = {i_group_idx, i_beat_idx};

    always_ff @(posedge clk)
    begin
        if (i_rd_en)
        begin
            o_samples <= mem[rd_bank][rd_addr];
        end
    end

    // on release the controller already looks at the other bank
    assign o_full_next = full_q[rd_bank ^ i_release];
    assign o_head      = head_mem[rd_bank];
    assign o_shift     = shift_mem[rd_bank];

    // readout must have freed the bank before the next packet starts
    sop_into_free_bank: assert property (@(posedge clk) disable iff (rst)
        (i_beat.vld && i_beat.sop) |-> !full_q[wr_bank]);

    eop_on_last_beat: assert property (@(posedge clk) disable iff (rst)
        pkt_end |-> (wr_addr == `CP_ADDR_W'(`CP_PKT_BEATS - 1)));

endmodule

// ==== pkt_capture.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module pkt_capture (
    input  logic                       clk,
    input  logic                       rst,
    input  cpri_pkt_pkg::beat_t        i_beat,
    output cpri_pkt_pkg::pkt_head_t    o_head,
    output cpri_pkt_pkg::shift_words_t o_shift
);

    cpri_pkt_pkg::pkt_head_t head_q;
    cpri_pkt_pkg::pkt_head_t head_beat;
    logic [`CP_ANT_NUM-1:0][7:0][`CP_SHIFT_W-1:0] nib_q;
    logic [`CP_ANT_NUM-1:0][7:0][`CP_SHIFT_W-1:0] nib_d;
    logic take_head;

    assign take_head = i_beat.vld && i_beat.sop;

    always_comb
    begin
        head_beat          = '0;
        head_beat.ch_type  = i_beat.ch_type;
        head_beat.cell_idx = i_beat.cell_idx;
        head_beat.slot_idx = i_beat.slot_idx;
        head_beat.sym_idx  = i_beat.sym_idx;
        head_beat.prb_idx  = i_beat.prb_idx;
        head_beat.info_hi  = i_beat.info_hi;
    end

    always_ff @(posedge clk)
    begin
        if (take_head)
        begin
            head_q <= head_beat;
        end
    end

    // sop beat is visible in the same cycle
    assign o_head = take_head ? head_beat : head_q;

    // ------------------------------------------------
    // shift nibbles, slot picked by prb_idx low bits
    // ------------------------------------------------
    always_comb
    begin
        nib_d = nib_q;
        if (i_beat.vld)
        begin
            if (i_beat.sop)
            begin
                nib_d = '0;
            end
            for (int a = 0; a < `CP_ANT_NUM; a++)
            begin
                nib_d[a][i_beat.prb_idx[2:0]] = i_beat.lane[a].shift;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            nib_q <= '0;
        end
        else
        begin
            nib_q <= nib_d;
        end
    end

    assign o_shift.word0 = {nib_d[1], nib_d[0]};
    assign o_shift.word1 = {nib_d[3], nib_d[2]};

endmodule

// ==== readout_fsm.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module readout_fsm (
    input  logic clk,
    input  logic rst,
    input  logic i_full_next,
    input  logic i_last,
    output logic o_rd_en,
    output logic o_release
);

    typedef enum logic {
        ST_IDLE,
        ST_READ
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= ST_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (i_full_next)
                begin
                    state_d = ST_READ;
                end
            end
            ST_READ:
            begin
                // back to back readout when the other bank is waiting
                if (i_last && !i_full_next)
                begin
                    state_d = ST_IDLE;
                end
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign o_rd_en   = (state_q == ST_READ);
    assign o_release = o_rd_en && i_last;

    // end of packet from the counter only comes after a full burst of reads
    release_after_burst: assert property (@(posedge clk) disable iff (rst)
        i_last |-> (state_q == ST_READ) && $past(o_rd_en, `CP_PKT_BEATS - 1));

endmodule

// ==== run.sh ====
#!/bin/sh
# build with assertions on, then look for the pass line in the simulation output
verilator --binary --timing --assert -j 0 --top-module tb_cpri_pack -f build.f \
    || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/Vtb_cpri_pack)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST OK" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== slot_mapper.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module slot_mapper (
    input  logic                       clk,
    input  logic                       rst,
    input  cpri_frame_pkg::lanes16_t   i_lanes,
    input  cpri_frame_pkg::rd_step_t   i_step,
    input  logic                       i_rd_vld,
    input  cpri_pkt_pkg::pkt_head_t    i_head,
    input  cpri_pkt_pkg::shift_words_t i_shift,
    output cpri_frame_pkg::cpri_wr_t   o_wr
);

    logic [1:0]                 vld_pipe;
    logic                       wen_q;
    logic                       wlast_q;
    logic [`CP_ADDR_W-1:0]      waddr_q;
    logic [`CP_ADDR_W-1:0]      slot_addr;
    cpri_frame_pkg::cpri_word_u wdata_q;
    cpri_frame_pkg::cpri_word_u slot_word;

    // read enable to packer output is two cycles
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            vld_pipe <= '0;
            wen_q    <= 1'b0;
            wlast_q  <= 1'b0;
        end
        else
        begin
            vld_pipe <= {vld_pipe[0], i_rd_vld};
            wen_q    <= vld_pipe[1];
            wlast_q  <= vld_pipe[1] && i_step.last;
        end
    end

    // ------------------------------------------------
    // slot words, low slots then the top five
    // ------------------------------------------------
    always_comb
    begin
        if (i_step.group_idx < 4'(`CP_DATA_BASE))
        begin
            slot_addr = `CP_ADDR_W'(i_step.group_idx);
        end
        else
        begin
            slot_addr = `CP_ADDR_W'(`CP_HIGH_SLOT_BASE - `CP_DATA_BASE) +
                        `CP_ADDR_W'(i_step.group_idx);
        end

        slot_word = '0;
        case (i_step.group_idx)
            4'd3:    slot_word.head = i_head;
            4'd5:    slot_word = cpri_frame_pkg::cpri_word_u'(i_shift.word0);
            4'd6:    slot_word = cpri_frame_pkg::cpri_word_u'(i_shift.word1);
            default: slot_word = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_step.beat_idx == 3'd0)
        begin
            waddr_q <= slot_addr;
            wdata_q <= slot_word;
        end
        else
        begin
            waddr_q       <= i_step.data_addr;
            wdata_q.lanes <= i_lanes;
        end
    end

    assign o_wr = '{wen: wen_q, waddr: waddr_q, wdata: wdata_q, wlast: wlast_q};

endmodule

// ==== tb_cpri_pack.sv ====
`timescale 1ns/10ps
`include "cpri_pack_cfg.svh"

module tb_cpri_pack;

    localparam int NUM_PKTS        = 20;
    localparam int WATCHDOG_CYCLES = NUM_PKTS * `CP_PKT_BEATS * 4 * 2;

    logic                     clk;
    logic                     rst;
    cpri_pkt_pkg::beat_t      i_beat;
    cpri_frame_pkg::cpri_wr_t o_wr;

    // current packet and the expected write stream
    cpri_pkt_pkg::beat_t        pkt_beats [`CP_PKT_BEATS];
    cpri_frame_pkg::cpri_word_u exp_word_q [$];
    logic [`CP_ADDR_W-1:0]      exp_addr_q [$];
    bit                         exp_last_q [$];
    int                         eops_sent   = 0;
    int                         writes_seen = 0;
    int                         burst_pos   = 0;

    cpri_pack_top cpri_pack_top_i (
        .clk    (clk),
        .rst    (rst),
        .i_beat (i_beat),
        .o_wr   (o_wr)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------
    // failure and compare tasks
    // ------------------------------------------------
    task automatic report_failure();
        $display("TEST FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_word(input cpri_frame_pkg::cpri_word_u got,
                              input cpri_frame_pkg::cpri_word_u exp);
        if (got !== exp)
        begin
            $display("Error at %0t: o_wr.wdata expected %h got %h", $time, exp, got);
            report_failure();
        end
    endtask

    task automatic check_addr(input logic [`CP_ADDR_W-1:0] got,
                              input logic [`CP_ADDR_W-1:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t: o_wr.waddr expected %0d got %0d", $time, exp, got);
            report_failure();
        end
    endtask

    task automatic check_last(input bit got, input bit exp);
        if (got !== exp)
        begin
            $display("Error at %0t: o_wr.wlast expected %0b got %0b", $time, exp, got);
            report_failure();
        end
    endtask

    // ------------------------------------------------
    // stimulus and reference model
    // ------------------------------------------------
    task automatic make_packet();
        int prb_span;
        // a narrow prb range leaves the upper shift nibbles unwritten
        prb_span = $urandom_range(8, 1);
        for (int b = 0; b < `CP_PKT_BEATS; b++)
        begin
            pkt_beats[b]          = '0;
            pkt_beats[b].vld      = 1'b1;
            pkt_beats[b].sop      = (b == 0);
            pkt_beats[b].eop      = (b == `CP_PKT_BEATS - 1);
            pkt_beats[b].ch_type  = 4'($urandom);
            pkt_beats[b].cell_idx = 1'($urandom);
            pkt_beats[b].slot_idx = 7'($urandom);
            pkt_beats[b].sym_idx  = 4'($urandom);
            pkt_beats[b].prb_idx  = 9'($urandom);
            pkt_beats[b].prb_idx[2:0] = 3'($urandom_range(prb_span - 1, 0));
            pkt_beats[b].info_hi  = 4'($urandom);
            for (int a = 0; a < `CP_ANT_NUM; a++)
            begin
                pkt_beats[b].lane[a].sample = 14'($urandom);
                pkt_beats[b].lane[a].shift  = 4'($urandom);
            end
        end
    endtask

    task automatic predict_packet();
        cpri_pkt_pkg::pkt_head_t    head;
        cpri_frame_pkg::cpri_word_u word;
        logic [31:0]                shift_ant [`CP_ANT_NUM];
        logic [8*`CP_SAMPLE_W-1:0]  joined [`CP_ANT_NUM];
        head          = '0;
        head.ch_type  = pkt_beats[0].ch_type;
        head.cell_idx = pkt_beats[0].cell_idx;
        head.slot_idx = pkt_beats[0].slot_idx;
        head.sym_idx  = pkt_beats[0].sym_idx;
        head.prb_idx  = pkt_beats[0].prb_idx;
        head.info_hi  = pkt_beats[0].info_hi;
        // last beat with a given prb_idx[2:0] owns that nibble
        for (int a = 0; a < `CP_ANT_NUM; a++)
        begin
            shift_ant[a] = '0;
            for (int b = 0; b < `CP_PKT_BEATS; b++)
            begin
                shift_ant[a][4*pkt_beats[b].prb_idx[2:0] +: 4] = pkt_beats[b].lane[a].shift;
            end
        end
        for (int g = 0; g < `CP_GROUP_NUM; g++)
        begin
            word = '0;
            case (g)
                3:       word.head = head;
                5:       word = {shift_ant[1], shift_ant[0]};
                6:       word = {shift_ant[3], shift_ant[2]};
                default: word = '0;
            endcase
            exp_word_q.push_back(word);
            exp_addr_q.push_back((g < 7) ? g : `CP_HIGH_SLOT_BASE + g - 7);
            exp_last_q.push_back(1'b0);
            for (int a = 0; a < `CP_ANT_NUM; a++)
            begin
                for (int s = 0; s < `CP_GROUP_BEATS; s++)
                begin
                    joined[a][`CP_SAMPLE_W*s +: `CP_SAMPLE_W] =
                        pkt_beats[g*`CP_GROUP_BEATS + s].lane[a].sample;
                end
            end
            // seven 16 bit slices per lane
            for (int k = 1; k < `CP_GROUP_BEATS; k++)
            begin
                word = '0;
                for (int a = 0; a < `CP_ANT_NUM; a++)
                begin
                    word.lanes.lane[a] = joined[a][16*(k-1) +: 16];
                end
                exp_word_q.push_back(word);
                exp_addr_q.push_back(`CP_DATA_BASE + 7*g + k - 1);
                exp_last_q.push_back((g == `CP_GROUP_NUM - 1) && (k == `CP_GROUP_BEATS - 1));
            end
        end
    endtask

    task automatic drive_packet();
        int gap;
        for (int b = 0; b < `CP_PKT_BEATS; b++)
        begin
            gap = $urandom_range(3, 0);
            repeat (gap)
            begin
                @(negedge clk);
                i_beat = '0;
            end
            @(negedge clk);
            i_beat = pkt_beats[b];
            if (pkt_beats[b].eop)
            begin
                eops_sent++;
            end
        end
    endtask

    // ------------------------------------------------
    // output monitor
    // ------------------------------------------------
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (o_wr.wen)
            begin
                if (exp_addr_q.size() == 0)
                begin
                    $display("write to address %0d with no packet pending", o_wr.waddr);
                    report_failure();
                end
                if (burst_pos == 0 && writes_seen / `CP_PKT_BEATS >= eops_sent)
                begin
                    $display("write burst started before its packet was complete");
                    report_failure();
                end
                check_addr(o_wr.waddr, exp_addr_q.pop_front());
                check_word(o_wr.wdata, exp_word_q.pop_front());
                check_last(o_wr.wlast, exp_last_q.pop_front());
                burst_pos = (burst_pos == `CP_PKT_BEATS - 1) ? 0 : burst_pos + 1;
                writes_seen++;
            end
            else
            begin
                check_last(o_wr.wlast, 1'b0);
                if (burst_pos != 0)
                begin
                    $display("write burst broke off after %0d words", burst_pos);
                    report_failure();
                end
            end
        end
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        report_failure();
    end

    initial
    begin
        void'($urandom(32'h2acae9d1));
        rst    = 1'b1;
        i_beat = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int p = 0; p < NUM_PKTS; p++)
        begin
            make_packet();
            predict_packet();
            drive_packet();
        end
        @(negedge clk);
        i_beat = '0;
        while (exp_addr_q.size() != 0)
        begin
            @(negedge clk);
        end
        // let stray writes show up
        repeat (8) @(negedge clk);
        if (writes_seen != NUM_PKTS * `CP_PKT_BEATS)
        begin
            $display("expected %0d writes but saw %0d", NUM_PKTS * `CP_PKT_BEATS, writes_seen);
            report_failure();
        end
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
